/* design/msu_pkg.sv */
package msu_pkg;

  ////////////////////////////////////////
  // Buffer geometry
  ////////////////////////////////////////

  localparam int BUF_AW = 14;

  ////////////////////////////////////////
  // Host register offsets
  ////////////////////////////////////////

  // Read side, offsets 2 to 7 return the ID string
  localparam logic [2:0] REG_STATUS = 3'd0;
  localparam logic [2:0] REG_DATA   = 3'd1;

  // Write side
  localparam logic [2:0] REG_SEEK0  = 3'd0;
  localparam logic [2:0] REG_SEEK1  = 3'd1;
  localparam logic [2:0] REG_SEEK2  = 3'd2;
  localparam logic [2:0] REG_SEEK3  = 3'd3;
  localparam logic [2:0] REG_TRACK0 = 3'd4;
  localparam logic [2:0] REG_TRACK1 = 3'd5;
  localparam logic [2:0] REG_VOLUME = 3'd6;
  localparam logic [2:0] REG_CTRL   = 3'd7;

  // "S-MSU1"
  localparam logic [7:0] ID_BYTES [0:5] = '{8'h53, 8'h2d, 8'h4d, 8'h53, 8'h55, 8'h31};

  ////////////////////////////////////////
  // Status set/clear vector bits
  ////////////////////////////////////////

  localparam int ST_CTRL_START    = 0;
  localparam int ST_AUDIO_STAT_LO = 1;
  localparam int ST_AUDIO_STAT_HI = 2;
  localparam int ST_AUDIO_ERR     = 3;
  localparam int ST_DATA_BUSY     = 4;
  localparam int ST_AUDIO_BUSY    = 5;

  // Fixed low field of the status read byte
  localparam logic [2:0] STATUS_LOW_BITS = 3'b001;

  ////////////////////////////////////////
  // Card sequencer
  ////////////////////////////////////////

  localparam int FILL_LEN          = 16;
  localparam int AUDIO_SEEK_CYCLES = 20;
  localparam int MAX_TRACK         = 99;
  localparam int CNT_W             = 8;

endpackage

/* design/msu_count_timer.sv */
`timescale 1ns/1ps

module msu_count_timer #(
  parameter int WIDTH = msu_pkg::CNT_W
) (
  input  logic             clkin,
  input  logic             arst_n,
  input  logic             load,
  input  logic [WIDTH-1:0] load_value,
  input  logic             dec,
  output logic [WIDTH-1:0] count,
  output logic             done
);

  // Load has priority, count holds at zero
  always_ff @(posedge clkin or negedge arst_n) begin
    if (!arst_n) begin
      count <= '0;
    end else if (load) begin
      count <= load_value;
    end else if (dec && count != '0) begin
      count <= count - 1'b1;
    end
  end

  assign done = (count == '0);

endmodule

/* design/msu_databuf.sv */
`timescale 1ns/1ps

module msu_databuf (
  input  logic                       clkin,
  input  logic                       buf_we,
  input  logic [msu_pkg::BUF_AW-1:0] buf_waddr,
  input  logic [7:0]                 buf_wdata,
  input  logic [msu_pkg::BUF_AW-1:0] rd_addr,
  output logic [7:0]                 rd_data
);

  // 16 KiB, maps to block RAM
  logic [7:0] mem [0:(2**msu_pkg::BUF_AW)-1];

  // Card write port
  always_ff @(posedge clkin) begin
    if (buf_we)
      mem[buf_waddr] <= buf_wdata;
  end

  // Host read port, one clock latency
  always_ff @(posedge clkin) begin
    rd_data <= mem[rd_addr];
  end

endmodule

/* design/msu_regs.sv */
`timescale 1ns/1ps

module msu_regs (
  input  logic                       clkin,
  input  logic                       arst_n,
  input  logic                       enable,
  input  logic [2:0]                 reg_addr,
  input  logic [7:0]                 reg_data_in,
  input  logic                       reg_oe_falling,
  input  logic                       reg_oe_rising,
  input  logic                       reg_we_rising,
  input  logic [7:0]                 rd_data,
  input  logic [5:0]                 status_set_bits,
  input  logic [5:0]                 status_reset_bits,
  input  logic                       status_reset_we,
  input  logic [msu_pkg::BUF_AW-1:0] address_ext,
  input  logic                       address_ext_write,
  output logic [7:0]                 reg_data_out,
  output logic [7:0]                 status_out,
  output logic [7:0]                 volume_out,
  output logic                       volume_latch_out,
  output logic [31:0]                addr_out,
  output logic [15:0]                track_out,
  output logic [msu_pkg::BUF_AW-1:0] rd_addr,
  output logic                       data_start,
  output logic                       audio_start
);

  logic [1:0]                 status_we_sync;
  logic [2:0]                 ext_write_sreg;
  logic                       status_update;
  logic                       ext_write_rise;
  logic                       wr_en;
  logic                       rd_en;
  logic [2:0]                 id_index;
  logic [msu_pkg::BUF_AW-1:0] ptr_r;

  // Status flags
  logic       data_start_r;
  logic       data_busy_r;
  logic       audio_start_r;
  logic       audio_busy_r;
  logic       audio_error_r;
  logic [1:0] audio_status_r;
  logic [2:0] audio_ctrl_r;
  logic       ctrl_start_r;

  assign wr_en    = reg_we_rising & enable;
  assign rd_en    = reg_oe_falling & enable;
  assign id_index = reg_addr - 3'd2;

  ////////////////////////////////////////
  // Card-side strobe synchronizers
  ////////////////////////////////////////

  always_ff @(posedge clkin or negedge arst_n) begin
    if (!arst_n) begin
      status_we_sync <= '0;
      ext_write_sreg <= '0;
    end else begin
      status_we_sync <= {status_we_sync[0], status_reset_we};
      ext_write_sreg <= {ext_write_sreg[1:0], address_ext_write};
    end
  end

  assign status_update  = (status_we_sync == 2'b01);
  assign ext_write_rise = (ext_write_sreg[2:1] == 2'b01);

  ////////////////////////////////////////
  // Read pointer and read mux
  ////////////////////////////////////////

  // External reload wins over a host data read
  always_ff @(posedge clkin or negedge arst_n) begin
    if (!arst_n) begin
      ptr_r <= '0;
    end else if (ext_write_rise) begin
      ptr_r <= address_ext;
    end else if (reg_oe_rising && enable && reg_addr == msu_pkg::REG_DATA) begin
      ptr_r <= ptr_r + 1'b1;
    end
  end

  assign rd_addr = ptr_r;

  always_ff @(posedge clkin or negedge arst_n) begin
    if (!arst_n) begin
      reg_data_out <= '0;
    end else if (rd_en) begin
      case (reg_addr)
        msu_pkg::REG_STATUS: reg_data_out <= {data_busy_r, audio_busy_r, audio_status_r,
                                              audio_error_r, msu_pkg::STATUS_LOW_BITS};
        msu_pkg::REG_DATA:   reg_data_out <= rd_data;
        default:             reg_data_out <= msu_pkg::ID_BYTES[id_index];
      endcase
    end
  end

  ////////////////////////////////////////
  // Write decode and status flags
  ////////////////////////////////////////

  always_ff @(posedge clkin or negedge arst_n) begin
    if (!arst_n) begin
      addr_out         <= '0;
      track_out        <= '0;
      volume_out       <= '0;
      volume_latch_out <= 1'b0;
      data_start_r     <= 1'b0;
      data_busy_r      <= 1'b1;
      audio_start_r    <= 1'b0;
      audio_busy_r     <= 1'b1;
      audio_error_r    <= 1'b0;
      audio_status_r   <= '0;
      audio_ctrl_r     <= '0;
      ctrl_start_r     <= 1'b0;
    end else begin
      // Volume latch is a single-cycle pulse
      volume_latch_out <= wr_en && (reg_addr == msu_pkg::REG_VOLUME);

      if (status_update) begin
        audio_busy_r <= (audio_busy_r | status_set_bits[msu_pkg::ST_AUDIO_BUSY])
                        & ~status_reset_bits[msu_pkg::ST_AUDIO_BUSY];
        if (status_reset_bits[msu_pkg::ST_AUDIO_BUSY])
          audio_start_r <= 1'b0;
        data_busy_r <= (data_busy_r | status_set_bits[msu_pkg::ST_DATA_BUSY])
                       & ~status_reset_bits[msu_pkg::ST_DATA_BUSY];
        if (status_reset_bits[msu_pkg::ST_DATA_BUSY])
          data_start_r <= 1'b0;
        audio_error_r <= (audio_error_r | status_set_bits[msu_pkg::ST_AUDIO_ERR])
                         & ~status_reset_bits[msu_pkg::ST_AUDIO_ERR];
        audio_status_r <= (audio_status_r
          | status_set_bits[msu_pkg::ST_AUDIO_STAT_HI:msu_pkg::ST_AUDIO_STAT_LO])
          & ~status_reset_bits[msu_pkg::ST_AUDIO_STAT_HI:msu_pkg::ST_AUDIO_STAT_LO];
        ctrl_start_r <= (ctrl_start_r | status_set_bits[msu_pkg::ST_CTRL_START])
                        & ~status_reset_bits[msu_pkg::ST_CTRL_START];
      end

      // A host write in the same cycle overrides the card update
      if (wr_en) begin
        case (reg_addr)
          msu_pkg::REG_SEEK0:  addr_out[7:0]   <= reg_data_in;
          msu_pkg::REG_SEEK1:  addr_out[15:8]  <= reg_data_in;
          msu_pkg::REG_SEEK2:  addr_out[23:16] <= reg_data_in;
          msu_pkg::REG_SEEK3: begin
            addr_out[31:24] <= reg_data_in;
            data_start_r    <= 1'b1;
            data_busy_r     <= 1'b1;
          end
          msu_pkg::REG_TRACK0: track_out[7:0] <= reg_data_in;
          msu_pkg::REG_TRACK1: begin
            track_out[15:8] <= reg_data_in;
            audio_start_r   <= 1'b1;
            audio_busy_r    <= 1'b1;
          end
          msu_pkg::REG_VOLUME: volume_out <= reg_data_in;
          msu_pkg::REG_CTRL: begin
            // Ignored while the audio seek is running
            if (!audio_busy_r) begin
              audio_ctrl_r <= reg_data_in[2:0];
              ctrl_start_r <= 1'b1;
            end
          end
        endcase
      end
    end
  end

  assign status_out = {ptr_r[msu_pkg::BUF_AW-1], audio_start_r, data_start_r,
                       volume_latch_out, audio_ctrl_r, ctrl_start_r};

  assign data_start  = status_out[5];
  assign audio_start = status_out[6];

endmodule

/* design/msu_card_fsm.sv */
`timescale 1ns/1ps

module msu_card_fsm (
  input  logic                       clkin,
  input  logic                       arst_n,
  input  logic                       data_start,
  input  logic                       audio_start,
  input  logic [msu_pkg::BUF_AW-1:0] seek_addr,
  input  logic [15:0]                track,
  input  logic                       fill_valid,
  input  logic [7:0]                 fill_data,
  input  logic                       fill_done,
  input  logic [msu_pkg::CNT_W-1:0]  fill_count,
  input  logic                       seek_done,
  output logic                       buf_we,
  output logic [msu_pkg::BUF_AW-1:0] buf_waddr,
  output logic [7:0]                 buf_wdata,
  output logic                       fill_load,
  output logic                       fill_dec,
  output logic                       seek_load,
  output logic                       seek_dec,
  output logic [msu_pkg::BUF_AW-1:0] address_ext,
  output logic                       address_ext_write,
  output logic [5:0]                 status_set_bits,
  output logic [5:0]                 status_reset_bits,
  output logic                       status_reset_we
);

  typedef enum logic [1:0] {D_IDLE, D_FILL, D_RELOAD, D_CLEAR} data_state_t;
  typedef enum logic [1:0] {A_IDLE, A_SEEK, A_REPORT} audio_state_t;
  typedef enum logic [1:0] {U_IDLE, U_SETUP, U_WE1, U_WE2} upd_phase_t;

  data_state_t  dstate;
  audio_state_t astate;
  upd_phase_t   uphase;

  logic data_start_q;
  logic audio_start_q;
  logic data_pend;
  logic audio_pend;
  logic data_accept;
  logic audio_accept;
  logic reload_second;
  logic track_err;
  logic upd_audio;
  logic data_upd_done;
  logic audio_upd_done;

  assign data_accept    = (dstate == D_IDLE) && data_pend;
  assign audio_accept   = (astate == A_IDLE) && audio_pend;
  assign data_upd_done  = (uphase == U_WE2) && !upd_audio;
  assign audio_upd_done = (uphase == U_WE2) && upd_audio;

  ////////////////////////////////////////
  // Start request latching
  ////////////////////////////////////////

  always_ff @(posedge clkin or negedge arst_n) begin
    if (!arst_n) begin
      data_start_q  <= 1'b0;
      audio_start_q <= 1'b0;
      data_pend     <= 1'b0;
      audio_pend    <= 1'b0;
    end else begin
      data_start_q  <= data_start;
      audio_start_q <= audio_start;
      if (data_start && !data_start_q)
        data_pend <= 1'b1;
      else if (data_accept)
        data_pend <= 1'b0;
      if (audio_start && !audio_start_q)
        audio_pend <= 1'b1;
      else if (audio_accept)
        audio_pend <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // Data and audio sequencers
  ////////////////////////////////////////

  always_ff @(posedge clkin or negedge arst_n) begin
    if (!arst_n) begin
      dstate        <= D_IDLE;
      astate        <= A_IDLE;
      reload_second <= 1'b0;
      track_err     <= 1'b0;
    end else begin
      case (dstate)
        D_IDLE:   if (data_accept) dstate <= D_FILL;
        D_FILL:   if (fill_done) dstate <= D_RELOAD;
        D_RELOAD: begin
          // Pointer reload strobe is two cycles wide
          reload_second <= !reload_second;
          if (reload_second)
            dstate <= D_CLEAR;
        end
        default:  if (data_upd_done) dstate <= D_IDLE;
      endcase

      case (astate)
        A_IDLE: begin
          if (audio_accept) begin
            track_err <= (track > msu_pkg::MAX_TRACK);
            astate    <= A_SEEK;
          end
        end
        A_SEEK:  if (seek_done) astate <= A_REPORT;
        default: if (audio_upd_done) astate <= A_IDLE;
      endcase
    end
  end

  assign fill_load = data_accept;
  assign fill_dec  = (dstate == D_FILL) && fill_valid && !fill_done;
  assign seek_load = audio_accept;
  assign seek_dec  = (astate == A_SEEK);

  // Bytes land at seek offset plus the number already written
  assign buf_we    = fill_dec;
  assign buf_wdata = fill_data;
  assign buf_waddr = seek_addr + msu_pkg::BUF_AW'(msu_pkg::FILL_LEN - fill_count);

  assign address_ext       = seek_addr;
  assign address_ext_write = (dstate == D_RELOAD);

  ////////////////////////////////////////
  // Status update arbiter, data first
  ////////////////////////////////////////

  always_ff @(posedge clkin or negedge arst_n) begin
    if (!arst_n) begin
      uphase    <= U_IDLE;
      upd_audio <= 1'b0;
    end else begin
      case (uphase)
        U_IDLE: begin
          if (dstate == D_CLEAR) begin
            upd_audio <= 1'b0;
            uphase    <= U_SETUP;
          end else if (astate == A_REPORT) begin
            upd_audio <= 1'b1;
            uphase    <= U_SETUP;
          end
        end
        U_SETUP: uphase <= U_WE1;
        U_WE1:   uphase <= U_WE2;
        default: uphase <= U_IDLE;
      endcase
    end
  end

  // Vectors held from setup until the write level drops
  always_comb begin
    status_set_bits   = '0;
    status_reset_bits = '0;
    if (uphase != U_IDLE) begin
      if (upd_audio) begin
        status_reset_bits[msu_pkg::ST_AUDIO_BUSY] = 1'b1;
        if (track_err) begin
          status_set_bits[msu_pkg::ST_AUDIO_ERR]       = 1'b1;
          status_reset_bits[msu_pkg::ST_AUDIO_STAT_LO] = 1'b1;
        end else begin
          status_set_bits[msu_pkg::ST_AUDIO_STAT_LO] = 1'b1;
          status_reset_bits[msu_pkg::ST_AUDIO_ERR]   = 1'b1;
        end
      end else begin
        status_reset_bits[msu_pkg::ST_DATA_BUSY] = 1'b1;
      end
    end
  end

  assign status_reset_we = (uphase == U_WE1) || (uphase == U_WE2);

endmodule

/* design/msu_top.sv */
`timescale 1ns/1ps

module msu_top (
  input  logic        clkin,
  input  logic        arst_n,
  input  logic        enable,
  input  logic [2:0]  reg_addr,
  input  logic [7:0]  reg_data_in,
  input  logic        reg_oe_falling,
  input  logic        reg_oe_rising,
  input  logic        reg_we_rising,
  input  logic        fill_valid,
  input  logic [7:0]  fill_data,
  output logic [7:0]  reg_data_out,
  output logic [7:0]  status_out,
  output logic [7:0]  volume_out,
  output logic        volume_latch_out,
  output logic [31:0] addr_out,
  output logic [15:0] track_out
);

  logic [msu_pkg::BUF_AW-1:0] rd_addr;
  logic [7:0]                 rd_data;
  logic                       buf_we;
  logic [msu_pkg::BUF_AW-1:0] buf_waddr;
  logic [7:0]                 buf_wdata;
  logic [5:0]                 status_set_bits;
  logic [5:0]                 status_reset_bits;
  logic                       status_reset_we;
  logic [msu_pkg::BUF_AW-1:0] address_ext;
  logic                       address_ext_write;
  logic                       data_start;
  logic                       audio_start;

  // Counter controls
  logic                      fill_load;
  logic                      fill_dec;
  logic                      fill_done;
  logic [msu_pkg::CNT_W-1:0] fill_count;
  logic                      seek_load;
  logic                      seek_dec;
  logic                      seek_done;

  msu_regs u_regs (
    .clkin             (clkin),
    .arst_n            (arst_n),
    .enable            (enable),
    .reg_addr          (reg_addr),
    .reg_data_in       (reg_data_in),
    .reg_oe_falling    (reg_oe_falling),
    .reg_oe_rising     (reg_oe_rising),
    .reg_we_rising     (reg_we_rising),
    .rd_data           (rd_data),
    .status_set_bits   (status_set_bits),
    .status_reset_bits (status_reset_bits),
    .status_reset_we   (status_reset_we),
    .address_ext       (address_ext),
    .address_ext_write (address_ext_write),
    .reg_data_out      (reg_data_out),
    .status_out        (status_out),
    .volume_out        (volume_out),
    .volume_latch_out  (volume_latch_out),
    .addr_out          (addr_out),
    .track_out         (track_out),
    .rd_addr           (rd_addr),
    .data_start        (data_start),
    .audio_start       (audio_start)
  );

  msu_databuf u_databuf (
    .clkin     (clkin),
    .buf_we    (buf_we),
    .buf_waddr (buf_waddr),
    .buf_wdata (buf_wdata),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

  msu_card_fsm u_card_fsm (
    .clkin             (clkin),
    .arst_n            (arst_n),
    .data_start        (data_start),
    .audio_start       (audio_start),
    .seek_addr         (addr_out[msu_pkg::BUF_AW-1:0]),
    .track             (track_out),
    .fill_valid        (fill_valid),
    .fill_data         (fill_data),
    .fill_done         (fill_done),
    .fill_count        (fill_count),
    .seek_done         (seek_done),
    .buf_we            (buf_we),
    .buf_waddr         (buf_waddr),
    .buf_wdata         (buf_wdata),
    .fill_load         (fill_load),
    .fill_dec          (fill_dec),
    .seek_load         (seek_load),
    .seek_dec          (seek_dec),
    .address_ext       (address_ext),
    .address_ext_write (address_ext_write),
    .status_set_bits   (status_set_bits),
    .status_reset_bits (status_reset_bits),
    .status_reset_we   (status_reset_we)
  );

  // Remaining fill bytes
  msu_count_timer #(.WIDTH(msu_pkg::CNT_W)) u_fill_cnt (
    .clkin      (clkin),
    .arst_n     (arst_n),
    .load       (fill_load),
    .load_value (msu_pkg::CNT_W'(msu_pkg::FILL_LEN)),
    .dec        (fill_dec),
    .count      (fill_count),
    .done       (fill_done)
  );

  // Audio seek delay, only the terminal flag matters
  msu_count_timer #(.WIDTH(msu_pkg::CNT_W)) u_seek_tmr (
    .clkin      (clkin),
    .arst_n     (arst_n),
    .load       (seek_load),
    .load_value (msu_pkg::CNT_W'(msu_pkg::AUDIO_SEEK_CYCLES)),
    .dec        (seek_dec),
    .count      (),
    .done       (seek_done)
  );

endmodule

/* testbench/msu_checker.sv */
`timescale 1ns/1ps

module msu_checker (
  input logic       clkin,
  input logic       arst_n,
  input logic       enable,
  input logic [2:0] reg_addr,
  input logic       reg_we_rising,
  input logic       audio_busy,
  input logic [7:0] status_out,
  input logic       volume_latch_out,
  input logic       data_start,
  input logic       audio_start
);

  int assert_fails = 0;

  // Volume latch is a one-cycle pulse
  latch_single: assert property (@(posedge clkin) disable iff (!arst_n)
      volume_latch_out |=> !volume_latch_out)
    else begin
      assert_fails++;
      $error("volume_latch_out stayed high for two cycles");
    end

  // No start request comes out of reset
  start_after_reset: assert property (@(posedge clkin)
      $rose(arst_n) |-> (!data_start && !audio_start))
    else begin
      assert_fails++;
      $error("start flags set right after reset");
    end

  // Audio control field is frozen while the seek runs
  ctrl_guard: assert property (@(posedge clkin) disable iff (!arst_n)
      (reg_we_rising && enable && reg_addr == msu_pkg::REG_CTRL && audio_busy)
      |=> $stable(status_out[3:1]))
    else begin
      assert_fails++;
      $error("REG_CTRL write changed status_out[3:1] while audio busy");
    end

endmodule

bind msu_regs msu_checker u_checker (
  .clkin            (clkin),
  .arst_n           (arst_n),
  .enable           (enable),
  .reg_addr         (reg_addr),
  .reg_we_rising    (reg_we_rising),
  .audio_busy       (audio_busy_r),
  .status_out       (status_out),
  .volume_latch_out (volume_latch_out),
  .data_start       (data_start),
  .audio_start      (audio_start)
);

/* testbench/msu_tb.sv */
`timescale 1ns/1ps

module msu_tb;

  localparam int OP_WRITE      = 0;
  localparam int OP_READ       = 1;
  localparam int OP_FILL       = 2;
  localparam int OP_WAIT_DATA  = 3;
  localparam int OP_WAIT_AUDIO = 4;
  localparam int OP_STREAM     = 5;
  localparam int OP_VOLUME     = 6;
  localparam int OP_CHK_ADDR   = 7;
  localparam int OP_CHK_TRACK  = 8;
  localparam int OP_CHK_STATUS = 9;

  localparam int MAX_STEPS   = 40;
  localparam int POLL_LIMIT  = 50;
  localparam int STEP_CYCLES = msu_pkg::FILL_LEN * 4 + msu_pkg::AUDIO_SEEK_CYCLES + 40;

  logic        clkin;
  logic        arst_n;
  logic        enable;
  logic [2:0]  reg_addr;
  logic [7:0]  reg_data_in;
  logic        reg_oe_falling;
  logic        reg_oe_rising;
  logic        reg_we_rising;
  logic        fill_valid;
  logic [7:0]  fill_data;
  logic [7:0]  reg_data_out;
  logic [7:0]  status_out;
  logic [7:0]  volume_out;
  logic        volume_latch_out;
  logic [31:0] addr_out;
  logic [15:0] track_out;

  // Stimulus table, one column per field
  int          tbl_op   [MAX_STEPS];
  logic [2:0]  tbl_addr [MAX_STEPS];
  logic [31:0] tbl_data [MAX_STEPS];
  logic [31:0] tbl_exp  [MAX_STEPS];
  int          n_steps;

  // Reference copy of the bytes the card wrote
  logic [7:0]  model_mem [0:(2**msu_pkg::BUF_AW)-1];
  logic [31:0] lcg_state;

  int errors;
  int checks;
  int cycle_count;
  int cycle_limit;

  msu_top DUT (
    .clkin            (clkin),
    .arst_n           (arst_n),
    .enable           (enable),
    .reg_addr         (reg_addr),
    .reg_data_in      (reg_data_in),
    .reg_oe_falling   (reg_oe_falling),
    .reg_oe_rising    (reg_oe_rising),
    .reg_we_rising    (reg_we_rising),
    .fill_valid       (fill_valid),
    .fill_data        (fill_data),
    .reg_data_out     (reg_data_out),
    .status_out       (status_out),
    .volume_out       (volume_out),
    .volume_latch_out (volume_latch_out),
    .addr_out         (addr_out),
    .track_out        (track_out)
  );

  always #4 clkin = ~clkin;

  // Run length guard
  always @(posedge clkin) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: run stopped after %0d cycles", cycle_count);
      $display("Simulation failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic string op_name(input int op);
    case (op)
      OP_WRITE:      return "write";
      OP_READ:       return "read";
      OP_FILL:       return "fill burst";
      OP_WAIT_DATA:  return "wait data idle";
      OP_WAIT_AUDIO: return "wait audio idle";
      OP_STREAM:     return "data stream";
      OP_VOLUME:     return "volume";
      OP_CHK_ADDR:   return "check addr_out";
      OP_CHK_TRACK:  return "check track_out";
      OP_CHK_STATUS: return "check status_out";
      default:       return "unknown";
    endcase
  endfunction

  task automatic add_step(input int op, input logic [2:0] addr, input logic [31:0] data,
                          input logic [31:0] expected);
    tbl_op[n_steps]   = op;
    tbl_addr[n_steps] = addr;
    tbl_data[n_steps] = data;
    tbl_exp[n_steps]  = expected;
    n_steps++;
  endtask

  task automatic check_byte(input string name, input logic [7:0] actual,
                            input logic [7:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("mismatch at %0t: %s expected %02h actual %02h", $time, name, expected, actual);
    end
  endtask

  task automatic check_word32(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("mismatch at %0t: %s expected %08h actual %08h", $time, name, expected, actual);
    end
  endtask

  task automatic check_word16(input string name, input logic [15:0] actual,
                              input logic [15:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("mismatch at %0t: %s expected %04h actual %04h", $time, name, expected, actual);
    end
  endtask

  task automatic check_flag(input string name, input logic actual, input logic expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("mismatch at %0t: %s expected %b actual %b", $time, name, expected, actual);
    end
  endtask

  ////////////////////////////////////////
  // Host bus and card drivers
  ////////////////////////////////////////

  task automatic write_reg(input logic [2:0] addr, input logic [7:0] data);
    @(posedge clkin);
    enable        <= 1'b1;
    reg_addr      <= addr;
    reg_data_in   <= data;
    reg_we_rising <= 1'b1;
    @(posedge clkin);
    enable        <= 1'b0;
    reg_we_rising <= 1'b0;
  endtask

  // Advance adds the oe rising strobe that steps the read pointer
  task automatic read_reg(input logic [2:0] addr, input logic advance, output logic [7:0] data);
    @(posedge clkin);
    enable         <= 1'b1;
    reg_addr       <= addr;
    reg_oe_falling <= 1'b1;
    @(posedge clkin);
    enable         <= 1'b0;
    reg_oe_falling <= 1'b0;
    @(negedge clkin);
    data = reg_data_out;
    if (advance) begin
      @(posedge clkin);
      enable        <= 1'b1;
      reg_oe_rising <= 1'b1;
      @(posedge clkin);
      enable        <= 1'b0;
      reg_oe_rising <= 1'b0;
    end
  endtask

  task automatic wait_idle(input int bit_pos, input string what, input logic [7:0] expected);
    logic [7:0] status;
    int         polls;
    polls = 0;
    read_reg(msu_pkg::REG_STATUS, 1'b0, status);
    while (status[bit_pos] && polls < POLL_LIMIT) begin
      polls++;
      read_reg(msu_pkg::REG_STATUS, 1'b0, status);
    end
    if (status[bit_pos]) begin
      errors++;
      $display("error at %0t: %s sequence never finished within %0d status polls",
               $time, what, POLL_LIMIT);
    end else begin
      check_byte("reg_data_out (status)", status, expected);
    end
  endtask

  task automatic fill_burst(input logic [msu_pkg::BUF_AW-1:0] offset);
    logic [7:0] value;
    int         polls;
    int         i;
    polls = 0;
    // Card starts once the seek request shows on status_out
    while (!status_out[5] && polls < POLL_LIMIT) begin
      @(negedge clkin);
      polls++;
    end
    if (!status_out[5]) begin
      errors++;
      $display("error at %0t: data seek request never raised", $time);
    end else begin
      // Card access latency
      repeat (4) @(posedge clkin);
      for (i = 0; i < msu_pkg::FILL_LEN; i++) begin
        lcg_state = lcg_next(lcg_state);
        value     = lcg_state[23:16];
        model_mem[offset + msu_pkg::BUF_AW'(i)] = value;
        @(posedge clkin);
        fill_valid <= 1'b1;
        fill_data  <= value;
      end
      @(posedge clkin);
      fill_valid <= 1'b0;
    end
  endtask

  task automatic read_stream(input logic [msu_pkg::BUF_AW-1:0] offset);
    logic [7:0]                 value;
    logic [msu_pkg::BUF_AW-1:0] addr;
    int                         i;
    for (i = 0; i < msu_pkg::FILL_LEN; i++) begin
      addr = offset + msu_pkg::BUF_AW'(i);
      read_reg(msu_pkg::REG_DATA, 1'b1, value);
      check_byte($sformatf("reg_data_out (buffer %04h)", addr), value, model_mem[addr]);
    end
  endtask

  task automatic pulse_volume(input logic [7:0] data);
    write_reg(msu_pkg::REG_VOLUME, data);
    @(negedge clkin);
    check_flag("volume_latch_out", volume_latch_out, 1'b1);
    check_byte("volume_out", volume_out, data);
    @(negedge clkin);
    check_flag("volume_latch_out", volume_latch_out, 1'b0);
  endtask

  ////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////

  task automatic build_table();
    // ID string and reset status, both busy bits set
    add_step(OP_READ, 3'd2, 32'd0, "S");
    add_step(OP_READ, 3'd3, 32'd0, "-");
    add_step(OP_READ, 3'd4, 32'd0, "M");
    add_step(OP_READ, 3'd5, 32'd0, "S");
    add_step(OP_READ, 3'd6, 32'd0, "U");
    add_step(OP_READ, 3'd7, 32'd0, "1");
    add_step(OP_READ, msu_pkg::REG_STATUS, 32'd0, 32'hc1);
    // Audio still busy from reset, control write dropped
    add_step(OP_WRITE, msu_pkg::REG_CTRL, 32'h0e, 32'd0);
    add_step(OP_CHK_STATUS, 3'd0, 32'h0f, 32'h00);
    // Seek to 0x12345a60, buffer offset 0x1a60
    add_step(OP_WRITE, msu_pkg::REG_SEEK0, 32'h60, 32'd0);
    add_step(OP_WRITE, msu_pkg::REG_SEEK1, 32'h5a, 32'd0);
    add_step(OP_WRITE, msu_pkg::REG_SEEK2, 32'h34, 32'd0);
    add_step(OP_WRITE, msu_pkg::REG_SEEK3, 32'h12, 32'd0);
    add_step(OP_CHK_ADDR, 3'd0, 32'd0, 32'h12345a60);
    add_step(OP_CHK_STATUS, 3'd0, 32'h20, 32'h20);
    add_step(OP_FILL, 3'd0, 32'h1a60, 32'd0);
    add_step(OP_WAIT_DATA, 3'd0, 32'd0, 32'h41);
    add_step(OP_STREAM, 3'd0, 32'h1a60, 32'd0);
    add_step(OP_VOLUME, 3'd0, 32'ha5, 32'd0);
    // Highest valid track
    add_step(OP_WRITE, msu_pkg::REG_TRACK0, 32'h63, 32'd0);
    add_step(OP_WRITE, msu_pkg::REG_TRACK1, 32'h00, 32'd0);
    add_step(OP_CHK_TRACK, 3'd0, 32'd0, 32'h0063);
    add_step(OP_CHK_STATUS, 3'd0, 32'h40, 32'h40);
    add_step(OP_WAIT_AUDIO, 3'd0, 32'd0, 32'h11);
    add_step(OP_WRITE, msu_pkg::REG_CTRL, 32'h0e, 32'd0);
    add_step(OP_CHK_STATUS, 3'd0, 32'h0f, 32'h0d);
    // Track out of range
    add_step(OP_WRITE, msu_pkg::REG_TRACK0, 32'h64, 32'd0);
    add_step(OP_WRITE, msu_pkg::REG_TRACK1, 32'h01, 32'd0);
    add_step(OP_CHK_TRACK, 3'd0, 32'd0, 32'h0164);
    add_step(OP_WAIT_AUDIO, 3'd0, 32'd0, 32'h09);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    logic [7:0] rdata;
    int         err_before;
    int         s;
    clkin          = 1'b0;
    arst_n         = 1'b0;
    enable         = 1'b0;
    reg_addr       = '0;
    reg_data_in    = '0;
    reg_oe_falling = 1'b0;
    reg_oe_rising  = 1'b0;
    reg_we_rising  = 1'b0;
    fill_valid     = 1'b0;
    fill_data      = '0;
    lcg_state      = 32'd32093;
    errors         = 0;
    checks         = 0;
    n_steps        = 0;
    cycle_count    = 0;
    build_table();
    cycle_limit = n_steps * STEP_CYCLES;

    repeat (4) @(posedge clkin);
    arst_n <= 1'b1;

    for (s = 0; s < n_steps; s++) begin
      err_before = errors;
      case (tbl_op[s])
        OP_WRITE: write_reg(tbl_addr[s], tbl_data[s][7:0]);
        OP_READ: begin
          read_reg(tbl_addr[s], 1'b0, rdata);
          check_byte($sformatf("reg_data_out (offset %0d)", tbl_addr[s]), rdata,
                     tbl_exp[s][7:0]);
        end
        OP_FILL:       fill_burst(tbl_data[s][msu_pkg::BUF_AW-1:0]);
        OP_WAIT_DATA:  wait_idle(7, "data", tbl_exp[s][7:0]);
        OP_WAIT_AUDIO: wait_idle(6, "audio", tbl_exp[s][7:0]);
        OP_STREAM:     read_stream(tbl_data[s][msu_pkg::BUF_AW-1:0]);
        OP_VOLUME:     pulse_volume(tbl_data[s][7:0]);
        OP_CHK_ADDR: begin
          @(negedge clkin);
          check_word32("addr_out", addr_out, tbl_exp[s]);
        end
        OP_CHK_TRACK: begin
          @(negedge clkin);
          check_word16("track_out", track_out, tbl_exp[s][15:0]);
        end
        OP_CHK_STATUS: begin
          @(negedge clkin);
          check_byte($sformatf("status_out (mask %02h)", tbl_data[s][7:0]),
                     status_out & tbl_data[s][7:0], tbl_exp[s][7:0]);
        end
        default: begin
          errors++;
          $display("error: step %0d has an unknown operation %0d", s, tbl_op[s]);
        end
      endcase
      $display("step %0d %s %s", s, op_name(tbl_op[s]),
               (errors == err_before) ? "ok" : "FAILED");
    end

    repeat (2) @(posedge clkin);
    $display("%0d steps, %0d checks, %0d errors, %0d assertion failures", n_steps, checks,
             errors, DUT.u_regs.u_checker.assert_fails);
    if (errors == 0 && DUT.u_regs.u_checker.assert_fails == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* sources.f */
design/msu_pkg.sv
design/msu_count_timer.sv
design/msu_databuf.sv
design/msu_regs.sv
design/msu_card_fsm.sv
design/msu_top.sv
testbench/msu_checker.sv
testbench/msu_tb.sv

/* Bender.yml */
package:
  name: msu_coprocessor

sources:
  - design/msu_pkg.sv
  - design/msu_count_timer.sv
  - design/msu_databuf.sv
  - design/msu_regs.sv
  - design/msu_card_fsm.sv
  - design/msu_top.sv
  - target: test
    files:
      - testbench/msu_checker.sv
      - testbench/msu_tb.sv
